// File: Makefile
TOP := tb_fetch

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TB PASSED"

lint:
	verilator --lint-only --timing -f list.f --top-module fetch_top

clean:
	rm -rf obj_dir

// File: list.f
+incdir+src
src/fetch_pkg.sv
src/redirect_arbiter.sv
src/branch_predictor.sv
src/fetch_pc.sv
src/fetch_queue.sv
src/fetch_top.sv
tests/tb_fetch.sv

// File: src/branch_predictor.sv
`default_nettype none

`include "fetch_defs.svh"

module branch_predictor import fetch_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic [`XLEN-1:0]   lookup_pc,
  input  logic               lookup_fire,
  input  logic               upd_valid,
  input  logic [`XLEN-1:0]   upd_pc,
  input  pred_kind_e         upd_kind,
  input  logic               upd_taken,
  input  logic [`XLEN-1:0]   upd_target,
  input  logic               upd_call,
  input  logic [`XLEN-1:0]   upd_npc,
  input  logic               flush,
  output logic               pred_taken,
  output logic [`XLEN-1:0]   pred_target
);

  localparam int IDX_W = $clog2(`BTB_ENTRIES);
  localparam int TAG_W = `XLEN - IDX_W - 1;
  localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

  logic [`BTB_ENTRIES-1:0] btb_valid;
  logic [TAG_W-1:0]        btb_tag    [`BTB_ENTRIES];
  pred_kind_e              btb_kind   [`BTB_ENTRIES];
  logic [`XLEN-1:0]        btb_target [`BTB_ENTRIES];
  logic [1:0]              btb_ctr    [`BTB_ENTRIES];

  logic [`XLEN-1:0]        ras        [`RAS_DEPTH];
  logic [CNT_W-1:0]        ras_cnt;

  logic [IDX_W-1:0] lk_idx;
  logic [IDX_W-1:0] up_idx;
  logic [TAG_W-1:0] lk_tag;
  logic [TAG_W-1:0] up_tag;
  logic             lk_hit;
  logic             up_branch_hit;
  logic             ret_hit;
  logic             push;
  logic             pop;

  assign lk_idx = lookup_pc[IDX_W+1:2];
  assign lk_tag = {lookup_pc[`XLEN-1:IDX_W+2], lookup_pc[1]};
  assign up_idx = upd_pc[IDX_W+1:2];
  assign up_tag = {upd_pc[`XLEN-1:IDX_W+2], upd_pc[1]};

  assign lk_hit = btb_valid[lk_idx] && (btb_tag[lk_idx] == lk_tag);

  // Existing branch entry at the same address keeps training its counter.
  assign up_branch_hit = btb_valid[up_idx] && (btb_tag[up_idx] == up_tag) &&
                         (btb_kind[up_idx] == PRED_BRANCH) && (upd_kind == PRED_BRANCH);

  // Stack contents are not trusted in a redirect cycle.
  assign ret_hit = lk_hit && (btb_kind[lk_idx] == PRED_RETURN) &&
                   (ras_cnt != '0) && !flush;

  assign push = upd_valid && upd_call;
  assign pop  = lookup_fire && ret_hit;

  always_comb begin
    pred_taken  = 1'b0;
    pred_target = btb_target[lk_idx];
    if (lk_hit) begin
      case (btb_kind[lk_idx])
        PRED_JUMP:   pred_taken = 1'b1;
        PRED_BRANCH: pred_taken = btb_ctr[lk_idx][1];  // Counter 2 or 3.
        PRED_RETURN: begin
          pred_taken  = ret_hit;
          pred_target = ras[0];
        end
        default:     pred_taken = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      btb_valid <= '0;
    end else if (upd_valid) begin
      btb_valid[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (upd_valid) begin
      btb_tag[up_idx]    <= up_tag;
      btb_kind[up_idx]   <= upd_kind;
      btb_target[up_idx] <= upd_target;
      if (!up_branch_hit) begin
        btb_ctr[up_idx] <= 2'd2;  // Weakly taken on allocation.
      end else if (upd_taken && btb_ctr[up_idx] != 2'd3) begin
        btb_ctr[up_idx] <= btb_ctr[up_idx] + 2'd1;
      end else if (!upd_taken && btb_ctr[up_idx] != 2'd0) begin
        btb_ctr[up_idx] <= btb_ctr[up_idx] - 2'd1;
      end
    end
  end

  // Entry 0 is the top; a push onto a full stack drops the bottom.
  always_ff @(posedge clock) begin
    if (push) begin
      ras[0] <= upd_npc;
      if (!pop) begin
        for (int i = 1; i < `RAS_DEPTH; i++) begin
          ras[i] <= ras[i-1];
        end
      end
    end else if (pop) begin
      for (int i = 0; i < `RAS_DEPTH - 1; i++) begin
        ras[i] <= ras[i+1];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ras_cnt <= '0;
    end else if (push && !pop && ras_cnt != CNT_W'(`RAS_DEPTH)) begin
      ras_cnt <= ras_cnt + 1'b1;
    end else if (pop && !push) begin
      ras_cnt <= ras_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Address and instruction width, one word.
`define XLEN 32

// First fetch address after reset.
`define RESET_PC 32'h0000_0100

// Branch target buffer entries.
// Index is pc[5:2]; tag is the upper bits together with pc[1].
`define BTB_ENTRIES 16

// Return address stack depth.
`define RAS_DEPTH 4

// Decode queue depth, a power of two.
`define QUEUE_DEPTH 4

`endif

// File: src/fetch_pc.sv
`default_nettype none

`include "fetch_defs.svh"

module fetch_pc import fetch_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  input  logic               redirect_valid,
  input  logic [`XLEN-1:0]   redirect_pc,
  input  redirect_src_e      redirect_src,
  input  logic               pred_taken,
  input  logic [`XLEN-1:0]   pred_target,
  input  logic               mem_ready,
  input  logic [`XLEN-1:0]   mem_rdata,
  input  logic               queue_full,
  output logic               mem_valid,
  output logic [`XLEN-1:0]   mem_addr,
  output logic               lookup_fire,
  output logic               push_valid,
  output logic [`XLEN-1:0]   push_pc,
  output logic [`XLEN-1:0]   push_instr,
  output logic               push_taken,
  output logic               flush
);

  logic [`XLEN-1:0] pc_q;
  logic [`XLEN-1:0] seq_pc;
  logic [`XLEN-1:0] next_pc;
  logic             transfer;
  logic             fence_redirect;
  logic             use_pred;

  // A redirect goes straight to memory in its own cycle.
  assign mem_addr = redirect_valid ? redirect_pc : pc_q;

  // The queue is flushed on a redirect, so there is room for the new entry.
  assign mem_valid = redirect_valid || !queue_full;

  assign transfer = mem_valid && mem_ready;

  assign fence_redirect = redirect_valid && (redirect_src == REDIR_FENCE);

  // Refetch after a fence goes sequentially.
  assign use_pred = pred_taken && !fence_redirect;

  assign lookup_fire = transfer && use_pred;

  // Full word for 11 in the low bits, otherwise a compressed halfword.
  assign seq_pc = mem_addr + ((mem_rdata[1:0] == 2'b11) ? `XLEN'(4) : `XLEN'(2));

  always_comb begin
    next_pc = pc_q;
    if (transfer) begin
      next_pc = use_pred ? pred_target : seq_pc;
    end else if (redirect_valid) begin
      next_pc = redirect_pc;  // Memory stalled, keep the target for retry.
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= next_pc;
    end
  end

  assign push_valid = transfer;
  assign push_pc    = mem_addr;
  assign push_instr = mem_rdata;
  assign push_taken = use_pred;

  assign flush = redirect_valid;

endmodule

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Winner of the redirect ranking.
  typedef enum logic [2:0] {
    REDIR_NONE       = 3'd0,
    REDIR_TRAP       = 3'd1,
    REDIR_MRET       = 3'd2,
    REDIR_MISPREDICT = 3'd3,
    REDIR_FENCE      = 3'd4
  } redirect_src_e;

  // Kind of control transfer held in a target buffer entry.
  typedef enum logic [1:0] {
    PRED_BRANCH = 2'd0,  // Conditional, uses the 2-bit counter.
    PRED_JUMP   = 2'd1,  // Always taken.
    PRED_RETURN = 2'd2   // Target comes from the return stack.
  } pred_kind_e;

endpackage

`default_nettype wire

// File: src/fetch_queue.sv
`default_nettype none

`include "fetch_defs.svh"

module fetch_queue (
  input  logic               clock,
  input  logic               reset,
  input  logic               flush,
  input  logic               push_valid,
  input  logic [`XLEN-1:0]   push_pc,
  input  logic [`XLEN-1:0]   push_instr,
  input  logic               push_taken,
  input  logic               out_ready,
  output logic               queue_full,
  output logic               out_valid,
  output logic [`XLEN-1:0]   out_pc,
  output logic [`XLEN-1:0]   out_instr,
  output logic               out_taken
);

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);

  logic [`XLEN-1:0] pc_mem    [`QUEUE_DEPTH];
  logic [`XLEN-1:0] instr_mem [`QUEUE_DEPTH];
  logic             taken_mem [`QUEUE_DEPTH];

  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W:0]   count;
  logic [PTR_W-1:0] wr_addr;
  logic             do_push;
  logic             do_pop;

  assign queue_full = (count == (PTR_W+1)'(`QUEUE_DEPTH));
  assign out_valid  = (count != '0);

  assign do_push = push_valid && (flush || !queue_full);
  assign do_pop  = out_valid && out_ready && !flush;  // A flush drops the head too.

  // After a flush the new entry lands at slot 0.
  assign wr_addr = flush ? '0 : wr_ptr;

  always_ff @(posedge clock) begin
    if (do_push) begin
      pc_mem[wr_addr]    <= push_pc;
      instr_mem[wr_addr] <= push_instr;
      taken_mem[wr_addr] <= push_taken;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= PTR_W'(do_push);
      count  <= (PTR_W+1)'(do_push);
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  assign out_pc    = pc_mem[rd_ptr];
  assign out_instr = instr_mem[rd_ptr];
  assign out_taken = taken_mem[rd_ptr];

endmodule

`default_nettype wire

// File: src/fetch_top.sv
`default_nettype none

`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
  input  logic               clock,
  input  logic               reset,
  output logic               mem_valid,
  output logic [`XLEN-1:0]   mem_addr,
  input  logic               mem_ready,
  input  logic [`XLEN-1:0]   mem_rdata,
  output logic               out_valid,
  output logic [`XLEN-1:0]   out_pc,
  output logic [`XLEN-1:0]   out_instr,
  output logic               out_taken,
  input  logic               out_ready,
  input  logic               resolve_valid,
  input  logic [`XLEN-1:0]   resolve_pc,
  input  pred_kind_e         resolve_kind,
  input  logic               resolve_taken,
  input  logic [`XLEN-1:0]   resolve_target,
  input  logic [`XLEN-1:0]   resolve_npc,
  input  logic [`XLEN-1:0]   resolve_next_pc,
  input  logic               resolve_call,
  input  logic               trap_valid,
  input  logic [`XLEN-1:0]   trap_vector,
  input  logic               mret_valid,
  input  logic [`XLEN-1:0]   mret_epc,
  input  logic               fence_valid,
  input  logic [`XLEN-1:0]   fence_pc
);

  logic             redirect_valid;
  logic [`XLEN-1:0] redirect_pc;
  redirect_src_e    redirect_src;
  logic             pred_taken;
  logic [`XLEN-1:0] pred_target;
  logic             lookup_fire;
  logic             flush;
  logic             queue_full;
  logic             push_valid;
  logic [`XLEN-1:0] push_pc;
  logic [`XLEN-1:0] push_instr;
  logic             push_taken;

  redirect_arbiter arbiter_i (
    .trap_valid      (trap_valid),
    .trap_vector     (trap_vector),
    .mret_valid      (mret_valid),
    .mret_epc        (mret_epc),
    .resolve_valid   (resolve_valid),
    .resolve_taken   (resolve_taken),
    .resolve_target  (resolve_target),
    .resolve_npc     (resolve_npc),
    .resolve_next_pc (resolve_next_pc),
    .fence_valid     (fence_valid),
    .fence_pc        (fence_pc),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc),
    .redirect_src    (redirect_src)
  );

  fetch_pc pc_i (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .redirect_src   (redirect_src),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .mem_ready      (mem_ready),
    .mem_rdata      (mem_rdata),
    .queue_full     (queue_full),
    .mem_valid      (mem_valid),
    .mem_addr       (mem_addr),
    .lookup_fire    (lookup_fire),
    .push_valid     (push_valid),
    .push_pc        (push_pc),
    .push_instr     (push_instr),
    .push_taken     (push_taken),
    .flush          (flush)
  );

  branch_predictor predictor_i (
    .clock       (clock),
    .reset       (reset),
    .lookup_pc   (mem_addr),
    .lookup_fire (lookup_fire),
    .upd_valid   (resolve_valid),
    .upd_pc      (resolve_pc),
    .upd_kind    (resolve_kind),
    .upd_taken   (resolve_taken),
    .upd_target  (resolve_target),
    .upd_call    (resolve_call),
    .upd_npc     (resolve_npc),
    .flush       (flush),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  fetch_queue queue_i (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .push_valid (push_valid),
    .push_pc    (push_pc),
    .push_instr (push_instr),
    .push_taken (push_taken),
    .out_ready  (out_ready),
    .queue_full (queue_full),
    .out_valid  (out_valid),
    .out_pc     (out_pc),
    .out_instr  (out_instr),
    .out_taken  (out_taken)
  );

endmodule

`default_nettype wire

// File: src/redirect_arbiter.sv
`default_nettype none

`include "fetch_defs.svh"

module redirect_arbiter import fetch_pkg::*; (
  input  logic               trap_valid,
  input  logic [`XLEN-1:0]   trap_vector,
  input  logic               mret_valid,
  input  logic [`XLEN-1:0]   mret_epc,
  input  logic               resolve_valid,
  input  logic               resolve_taken,
  input  logic [`XLEN-1:0]   resolve_target,
  input  logic [`XLEN-1:0]   resolve_npc,
  input  logic [`XLEN-1:0]   resolve_next_pc,
  input  logic               fence_valid,
  input  logic [`XLEN-1:0]   fence_pc,
  output logic               redirect_valid,
  output logic [`XLEN-1:0]   redirect_pc,
  output redirect_src_e      redirect_src
);

  logic [`XLEN-1:0] actual_pc;
  logic             mispredict;

  // Where the resolved instruction really goes next.
  assign actual_pc = resolve_taken ? resolve_target : resolve_npc;

  // Fetch followed a different path than the resolved one.
  assign mispredict = resolve_valid && (actual_pc != resolve_next_pc);

  always_comb begin
    redirect_valid = 1'b1;
    redirect_pc    = '0;
    redirect_src   = REDIR_NONE;
    if (trap_valid) begin
      redirect_pc  = trap_vector;
      redirect_src = REDIR_TRAP;
    end else if (mret_valid) begin
      redirect_pc  = mret_epc;
      redirect_src = REDIR_MRET;
    end else if (mispredict) begin
      redirect_pc  = actual_pc;
      redirect_src = REDIR_MISPREDICT;
    end else if (fence_valid) begin
      redirect_pc  = fence_pc;    // Refetch after the fence.
      redirect_src = REDIR_FENCE;
    end else begin
      redirect_valid = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_fetch.sv
`default_nettype none

`include "fetch_defs.svh"

module tb_fetch import fetch_pkg::*; ();

  localparam int ROWS = 13;
  localparam int TIMEOUT_CYCLES = ROWS * 40 + 100;
  localparam logic [`XLEN-1:0] COMPRESSED [3] = '{32'h108, 32'h10a, 32'h50c};

  typedef struct {
    int               stall;  // Random ready on memory and decode.
    int               count;  // Entries to take at the decode port.
    logic [`XLEN-1:0] first;  // Expected first PC after the event.
    int               trap;
    logic [`XLEN-1:0] vec;
    int               mret;
    logic [`XLEN-1:0] epc;
    int               fence;
    logic [`XLEN-1:0] fpc;
    int               res;
    logic [`XLEN-1:0] rpc;
    pred_kind_e       kind;
    int               taken;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] next;
    int               call;
  } row_t;

  logic             clock;
  logic             reset;
  logic             mem_valid;
  logic             mem_ready;
  logic [`XLEN-1:0] mem_addr;
  logic [`XLEN-1:0] mem_rdata;
  logic             out_valid;
  logic             out_ready;
  logic             out_taken;
  logic [`XLEN-1:0] out_pc;
  logic [`XLEN-1:0] out_instr;
  logic             resolve_valid;
  logic             resolve_taken;
  logic             resolve_call;
  logic [`XLEN-1:0] resolve_pc;
  logic [`XLEN-1:0] resolve_target;
  logic [`XLEN-1:0] resolve_npc;
  logic [`XLEN-1:0] resolve_next_pc;
  pred_kind_e       resolve_kind;
  logic             trap_valid;
  logic             mret_valid;
  logic             fence_valid;
  logic [`XLEN-1:0] trap_vector;
  logic [`XLEN-1:0] mret_epc;
  logic [`XLEN-1:0] fence_pc;

  row_t             rows [ROWS];
  integer           seed;
  int               cycles = 0;
  int               delivered;

  // Reference model state.
  logic [`XLEN-1:0] m_pc;
  logic [`XLEN-1:0] exp_pc_q [$];
  logic             exp_taken_q [$];
  logic [`XLEN-1:0] m_ras [$];  // Front is the top of the stack.
  logic             sb_valid  [`BTB_ENTRIES];
  logic [`XLEN-1:0] sb_pc     [`BTB_ENTRIES];
  pred_kind_e       sb_kind   [`BTB_ENTRIES];
  logic [`XLEN-1:0] sb_target [`BTB_ENTRIES];
  int               sb_ctr    [`BTB_ENTRIES];

  fetch_top dut_i (.*);

  always #4 clock = ~clock;

  assign mem_rdata = mem_word(mem_addr);

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles.", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "Run stopped by the cycle limit.");
    end
  end

  function automatic logic [`XLEN-1:0] mem_word(input logic [`XLEN-1:0] addr);
    logic [1:0] low;
    low = 2'b11;
    for (int i = 0; i < 3; i++) begin
      if (COMPRESSED[i] == addr) begin
        low = 2'b01;
      end
    end
    return {addr[`XLEN-1:2], low};
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    $display("TB FAILED");
    $fatal(1, "Stopped at the first mismatch.");
  endtask

  task automatic load_table();
    // stall count first trap vec mret epc fence fpc
    //   res pc kind taken target npc next call
    rows[0]  = '{0, 6, 'h100, 0, 0, 0, 0, 0, 0,
                 0, 0, PRED_BRANCH, 0, 0, 0, 0, 0};
    rows[1]  = '{0, 4, 'h400, 1, 'h400, 1, 'h500, 0, 0,
                 1, 'h300, PRED_BRANCH, 1, 'h600, 'h304, 'h304, 0};
    rows[2]  = '{0, 5, 'h500, 0, 0, 1, 'h500, 0, 0,
                 1, 'h310, PRED_BRANCH, 1, 'h640, 'h314, 'h314, 0};
    rows[3]  = '{0, 4, 'h700, 0, 0, 0, 0, 0, 0,
                 1, 'h320, PRED_BRANCH, 1, 'h700, 'h324, 'h324, 0};
    rows[4]  = '{0, 5, 'h318, 0, 0, 0, 0, 1, 'h318,
                 0, 0, PRED_BRANCH, 0, 0, 0, 0, 0};
    rows[5]  = '{0, 3, 'h324, 0, 0, 0, 0, 0, 0,
                 1, 'h320, PRED_BRANCH, 0, 'h700, 'h324, 'h700, 0};
    rows[6]  = '{0, 5, 'h318, 0, 0, 0, 0, 1, 'h318,
                 1, 'h320, PRED_BRANCH, 0, 'h700, 'h324, 'h324, 0};
    rows[7]  = '{0, 3, 'h344, 0, 0, 0, 0, 0, 0,
                 1, 'h810, PRED_RETURN, 1, 'h344, 'h814, 'h814, 0};
    rows[8]  = '{0, 7, 'h800, 0, 0, 0, 0, 0, 0,
                 1, 'h340, PRED_JUMP, 1, 'h800, 'h344, 'h344, 1};
    rows[9]  = '{1, 12, 'h100, 0, 0, 0, 0, 1, 'h100,
                 0, 0, PRED_BRANCH, 0, 0, 0, 0, 0};
    rows[10] = '{1, 8, 'h800, 0, 0, 0, 0, 0, 0,
                 1, 'h340, PRED_JUMP, 1, 'h800, 'h344, 'h344, 1};
    rows[11] = '{1, 8, 'h318, 0, 0, 1, 'h318, 0, 0,
                 0, 0, PRED_BRANCH, 0, 0, 0, 0, 0};
    rows[12] = '{0, 3, 'h340, 0, 0, 0, 0, 1, 'h340,
                 0, 0, PRED_BRANCH, 0, 0, 0, 0, 0};
  endtask

  task automatic reset_model();
    m_pc = `RESET_PC;
    exp_pc_q.delete();
    exp_taken_q.delete();
    m_ras.delete();
    for (int i = 0; i < `BTB_ENTRIES; i++) begin
      sb_valid[i] = 1'b0;
      sb_ctr[i]   = 0;
    end
  endtask

  task automatic drive_inputs(input row_t r, input logic event_cycle);
    trap_valid      = event_cycle && (r.trap != 0);
    trap_vector     = r.vec;
    mret_valid      = event_cycle && (r.mret != 0);
    mret_epc        = r.epc;
    fence_valid     = event_cycle && (r.fence != 0);
    fence_pc        = r.fpc;
    resolve_valid   = event_cycle && (r.res != 0);
    resolve_pc      = r.rpc;
    resolve_kind    = r.kind;
    resolve_taken   = (r.taken != 0);
    resolve_target  = r.target;
    resolve_npc     = r.npc;
    resolve_next_pc = r.next;
    resolve_call    = (r.call != 0);
    if (r.stall != 0) begin
      mem_ready = ($random(seed) & 3) != 0;
      out_ready = ($random(seed) & 3) != 0;
    end else begin
      mem_ready = 1'b1;
      out_ready = 1'b1;
    end
  endtask

  task automatic train_model();
    int idx;
    idx = int'(resolve_pc[5:2]);
    if (sb_valid[idx] && sb_pc[idx][`XLEN-1:1] == resolve_pc[`XLEN-1:1] &&
        sb_kind[idx] == PRED_BRANCH && resolve_kind == PRED_BRANCH) begin
      if (resolve_taken && sb_ctr[idx] < 3) begin
        sb_ctr[idx]++;
      end else if (!resolve_taken && sb_ctr[idx] > 0) begin
        sb_ctr[idx]--;
      end
    end else begin
      sb_ctr[idx] = 2;
    end
    sb_valid[idx]  = 1'b1;
    sb_pc[idx]     = resolve_pc;
    sb_kind[idx]   = resolve_kind;
    sb_target[idx] = resolve_target;
    if (resolve_call) begin
      m_ras.push_front(resolve_npc);
      if (m_ras.size() > `RAS_DEPTH) begin
        void'(m_ras.pop_back());  // Oldest return address falls off.
      end
    end
  endtask

  task automatic check_cycle(input row_t r);
    logic [`XLEN-1:0] actual;
    logic [`XLEN-1:0] redir_pc;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] word;
    logic             redir;
    logic             is_fence;
    logic             taken;
    logic             pop;
    logic             fetch_ok;
    int               idx;
    actual   = resolve_taken ? resolve_target : resolve_npc;
    redir    = 1'b1;
    is_fence = 1'b0;
    if (trap_valid) begin
      redir_pc = trap_vector;
    end else if (mret_valid) begin
      redir_pc = mret_epc;
    end else if (resolve_valid && actual != resolve_next_pc) begin
      redir_pc = actual;
    end else if (fence_valid) begin
      redir_pc = fence_pc;
      is_fence = 1'b1;
    end else begin
      redir_pc = '0;
      redir    = 1'b0;
    end
    addr   = redir ? redir_pc : m_pc;
    word   = mem_word(addr);
    idx    = int'(addr[5:2]);
    taken  = 1'b0;
    pop    = 1'b0;
    target = sb_target[idx];
    if (sb_valid[idx] && sb_pc[idx][`XLEN-1:1] == addr[`XLEN-1:1] && !is_fence) begin
      if (sb_kind[idx] == PRED_JUMP) begin
        taken = 1'b1;
      end else if (sb_kind[idx] == PRED_BRANCH) begin
        taken = sb_ctr[idx] >= 2;
      end else if (!redir && m_ras.size() > 0) begin
        taken  = 1'b1;
        pop    = 1'b1;
        target = m_ras[0];
      end
    end
    fetch_ok = (redir || exp_pc_q.size() < `QUEUE_DEPTH) && mem_ready;

    assert (mem_valid == (redir || exp_pc_q.size() < `QUEUE_DEPTH))
      else report_fail($sformatf("mem_valid %b differs from the model", mem_valid));
    assert (mem_addr == addr)
      else report_fail($sformatf("mem_addr %h, expected %h", mem_addr, addr));
    assert (out_valid == (exp_pc_q.size() > 0))
      else report_fail($sformatf("out_valid %b differs from the model", out_valid));
    if (exp_pc_q.size() > 0) begin
      assert (out_pc == exp_pc_q[0] && out_taken == exp_taken_q[0])
        else report_fail($sformatf("decode pc %h taken %b, expected pc %h taken %b",
                                   out_pc, out_taken, exp_pc_q[0], exp_taken_q[0]));
      assert (out_instr == mem_word(exp_pc_q[0]))
        else report_fail($sformatf("out_instr %h at pc %h", out_instr, out_pc));
    end

    if (redir) begin
      exp_pc_q.delete();  // Older entries never reach decode.
      exp_taken_q.delete();
    end else if (out_valid && out_ready) begin
      if (delivered == 0) begin
        assert (out_pc == r.first)
          else report_fail($sformatf("first pc %h after the event, expected %h",
                                     out_pc, r.first));
      end
      void'(exp_pc_q.pop_front());
      void'(exp_taken_q.pop_front());
      delivered++;
    end

    if (fetch_ok) begin
      exp_pc_q.push_back(addr);
      exp_taken_q.push_back(taken);
      if (pop) begin
        void'(m_ras.pop_front());
      end
      if (taken) begin
        m_pc = target;
      end else begin
        m_pc = addr + ((word[1:0] == 2'b11) ? 32'd4 : 32'd2);
      end
    end else if (redir) begin
      m_pc = redir_pc;
    end
    if (resolve_valid) begin
      train_model();
    end
  endtask

  initial begin
    clock     = 1'b0;
    reset     = 1'b0;
    seed      = 32'h4dce_86f6;
    delivered = 0;
    load_table();
    drive_inputs(rows[0], 1'b0);
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
    reset_model();
    for (int n = 0; n < ROWS; n++) begin
      delivered = 0;
      for (int c = 0; delivered < rows[n].count; c++) begin
        drive_inputs(rows[n], c == 0);
        #2;
        check_cycle(rows[n]);  // Outputs have settled before the next rising edge.
        @(negedge clock);
      end
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
